/* dv/tb_readback_table.svh */
`ifndef TB_READBACK_TABLE_SVH
`define TB_READBACK_TABLE_SVH

// Columns: action, address, write data, cycles, model check, expected A, expected B
// Expected A and B are compared on the last cycle of a read unless the model is used

task automatic load_table;
    // Cold start flag and version stamp
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 1, 1'b0, 32'h0, 32'h1);
    add_row(ACT_READ,  RB_VERSION,      32'h0, 1, 1'b0, VERSION_TB, BUILD_TB);
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 2, 1'b0, 32'h0, 32'h0);
    // Plain register readback
    add_row(ACT_WRITE, CFG_BIAS_U0,     32'h0000_1234, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_BIAS_MOD,    32'hFFFF_FF00, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_SRCS_MUX,    32'h0000_00A5, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_IN_MUX,      32'h0000_0C3C, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_BIAS,         32'h0, 1, 1'b0, 32'h0000_1134, 32'h0000_1234);
    add_row(ACT_READ,  RB_GVP_BIAS,     32'h0, 1, 1'b0, 32'h0, 32'hFFFF_FF00);
    add_row(ACT_READ,  RB_SRCS_MUX,     32'h0, 1, 1'b0, 32'h0000_00A5, 32'h0000_0C3C);
    add_row(ACT_READ,  RB_IN_MUX,       32'h0, 1, 1'b0, 32'h0000_0C3C, 32'h0);
    // Five steps, then clear
    add_row(ACT_WRITE, CFG_BIAS_SLOPE,  32'h0000_0010, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_Z_SLOPE,     32'hFFFF_FFFD, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_STEP,  32'h0,           32'h0, 5, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_GVP_BIAS,     32'h0, 1, 1'b0, 32'h0000_0050, 32'hFFFF_FF00);
    add_row(ACT_READ,  RB_Z,            32'h0, 1, 1'b0, 32'hFFFF_FFF1, 32'hFFFF_FFFD);
    add_row(ACT_READ,  RB_BIAS,         32'h0, 1, 1'b0, 32'h0000_1184, 32'h0000_1234);
    add_row(ACT_WRITE, CFG_GVP_CLEAR,   32'hDEAD_BEEF, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_GVP_BIAS,     32'h0, 1, 1'b0, 32'h0, 32'hFFFF_FF00);
    add_row(ACT_READ,  RB_Z,            32'h0, 1, 1'b0, 32'h0, 32'hFFFF_FFFD);
    // Clamp at both ends
    add_row(ACT_WRITE, CFG_BIAS_U0,     32'h7FFF_F000, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_BIAS_MOD,    32'h0000_2000, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_BIAS,         32'h0, 1, 1'b0, 32'h7FFF_FFFF, 32'h7FFF_F000);
    add_row(ACT_WRITE, CFG_BIAS_MOD,    32'hFFFF_0000, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_WRITE, CFG_BIAS_U0,     32'h8000_0100, 1, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_BIAS,         32'h0, 1, 1'b0, 32'h8000_0001, 32'h8000_0100);
    // State counter, one count per unmapped excursion
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 2, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  32'h0000_0BAD,   32'h0, 1, 1'b1, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 3, 1'b0, 32'h1, 32'h0);
    add_row(ACT_READ,  32'h0001_0000,   32'h0, 2, 1'b1, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 2, 1'b0, 32'h2, 32'h0);
    add_row(ACT_READ,  RB_VERSION,      32'h0, 1, 1'b0, VERSION_TB, BUILD_TB);
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 2, 1'b0, 32'h2, 32'h0);
    // Timing pairs and the default counter
    add_row(ACT_READ,  RB_TIMING_RESET, 32'h0, 2, 1'b0, 32'h0, 32'h0);
    add_row(ACT_READ,  32'h0000_7777,   32'h0, 4, 1'b1, 32'h0, 32'h0);
    add_row(ACT_READ,  RB_TIMING_TEST,  32'h0, 1, 1'b0, 32'h0773_5940, 32'h0000_0004);
    add_row(ACT_READ,  RB_TIMING_TEST,  32'h0, 1, 1'b0, 32'h0773_5940, 32'h0773_5940);
    add_row(ACT_READ,  RB_SYSTEM_STATE, 32'h0, 2, 1'b0, 32'h3, 32'h0);
endtask

`endif

/* dv/tb_spmc_readback.sv */
`timescale 1ns/100ps

module tb_spmc_readback;
    import spmc_pkg::*;

    localparam logic [31:0] VERSION_TB = 32'h0203_0A01;  // Stamp handed to the DUT
    localparam logic [31:0] BUILD_TB   = 32'hB1D0_0042;
    localparam int SETTLE_CYCLES = 3;   // Write to bias sum readback latency
    localparam int SETTLE_LIMIT  = 16;

    localparam logic [1:0] ACT_WRITE = 2'd0;
    localparam logic [1:0] ACT_STEP  = 2'd1;
    localparam logic [1:0] ACT_READ  = 2'd2;

    typedef struct packed {
        logic [1:0]  act;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] cnt;       // Cycles to hold a read or a step
        logic        by_model;  // Compare every cycle with the model
        logic [31:0] exp_a;
        logic [31:0] exp_b;
    } row_t;

    logic        aclk;
    logic        rst;
    logic        cfg_wr;
    logic [31:0] cfg_wr_addr;
    logic [31:0] cfg_wr_data;
    logic        gvp_step;
    logic [31:0] rb_addr;
    rb_pair_t    rb_data;

    row_t rows[$];
    int   seed;
    int   quiet_cycles;  // Edges since the last write or step
    int   n_checks;

    // Reference model state, one edge at a time
    logic [31:0] m_u0;
    logic [31:0] m_mod;
    logic [31:0] m_bslope;
    logic [31:0] m_zslope;
    logic [31:0] m_srcs;
    logic [31:0] m_in;
    logic        m_clear;
    logic [31:0] m_bgvp;
    logic [31:0] m_zgvp;
    logic [31:0] m_sum;
    logic [31:0] m_a;
    logic [31:0] m_b;
    logic [31:0] m_state;
    logic        m_arm;
    logic        m_startup;

    spmc_readback_top #(
        .VERSION_ID (VERSION_TB),
        .BUILD_DATE (BUILD_TB)
    ) uut (
        .aclk        (aclk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_data (cfg_wr_data),
        .gvp_step    (gvp_step),
        .rb_addr     (rb_addr),
        .rb_data     (rb_data)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;  // 20 ns period
    end

    task automatic add_row(input logic [1:0] act, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] cnt,
                           input logic by_model, input logic [31:0] exp_a,
                           input logic [31:0] exp_b);
        row_t r;
        r = '{act, addr, data, cnt, by_model, exp_a, exp_b};
        rows.push_back(r);
    endtask

    `include "tb_readback_table.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Total bias clamped to the package limits
    function automatic logic [31:0] sat_sum(input logic [31:0] u0, input logic [31:0] g,
                                            input logic [31:0] md);
        longint s;
        s = longint'($signed(u0)) + longint'($signed(g)) + longint'($signed(md));
        if (s > longint'(BIAS_MAX))
            return BIAS_MAX;
        else if (s < longint'(BIAS_MIN))
            return BIAS_MIN;
        return s[31:0];
    endfunction

    task automatic model_reset;
        {m_u0, m_mod, m_bslope, m_zslope, m_srcs, m_in} = '0;
        {m_clear, m_bgvp, m_zgvp, m_sum} = '0;
        {m_a, m_b, m_state, m_arm} = '0;
        m_startup    = 1'b1;  // Cold start reads as one
        quiet_cycles = 0;
    endtask

    // All next values from the old state, then commit
    task automatic model_edge;
        logic [31:0] na;
        logic [31:0] nb;
        logic [31:0] n_state;
        logic        n_arm;
        logic        n_startup;
        logic [31:0] n_sum;
        n_state   = m_state;
        n_arm     = m_arm;
        n_startup = m_startup;
        case (rb_addr)
            RB_Z:            {na, nb} = {m_zgvp, m_zslope};
            RB_BIAS:         {na, nb} = {m_sum, m_u0};
            RB_GVP_BIAS:     {na, nb} = {m_bgvp, m_mod};
            RB_SRCS_MUX:     {na, nb} = {m_srcs, m_in};
            RB_IN_MUX:       {na, nb} = {m_in, 32'h0};
            RB_TIMING_TEST:  {na, nb} = {32'd125000000, m_a};
            RB_TIMING_RESET: {na, nb} = 64'h0;
            RB_VERSION:      {na, nb, n_startup} = {VERSION_TB, BUILD_TB, 1'b0};
            RB_SYSTEM_STATE: {na, nb} = {m_state, 31'd0, m_startup};
            default:         {na, nb, n_arm} = {m_a + 32'd1, m_a + 32'd13, 1'b1};
        endcase
        if (rb_addr == RB_SYSTEM_STATE && m_arm)
            {n_state, n_arm} = {m_state + 32'd1, 1'b0};  // Armed visit counts once
        n_sum = sat_sum(m_u0, m_bgvp, m_mod);             // Registered one cycle late
        if (m_clear)
            {m_bgvp, m_zgvp} = 64'h0;                     // Clear beats a step
        else if (gvp_step)
            {m_bgvp, m_zgvp} = {m_bgvp + m_bslope, m_zgvp + m_zslope};
        m_clear = cfg_wr && (cfg_wr_addr == CFG_GVP_CLEAR);
        if (cfg_wr)
        begin
            case (cfg_wr_addr)
                CFG_BIAS_U0:    m_u0     = cfg_wr_data;
                CFG_BIAS_MOD:   m_mod    = cfg_wr_data;
                CFG_BIAS_SLOPE: m_bslope = cfg_wr_data;
                CFG_Z_SLOPE:    m_zslope = cfg_wr_data;
                CFG_SRCS_MUX:   m_srcs   = cfg_wr_data;
                CFG_IN_MUX:     m_in     = cfg_wr_data;
                default:        ;                           // Unknown address ignored
            endcase
        end
        {m_a, m_b, m_sum} = {na, nb, n_sum};
        {m_state, m_arm, m_startup} = {n_state, n_arm, n_startup};
        if (cfg_wr || gvp_step)
            quiet_cycles = 0;
        else
            quiet_cycles++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive, wait and compare
    ////////////////////////////////////////////////////////////////////////////

    // Model sees the inputs of this edge, new drives go out 2 ns later
    task automatic tick;
        @(posedge aclk);
        model_edge();
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic settle;
        int guard;
        guard = 0;
        while (quiet_cycles < SETTLE_CYCLES)
        begin
            if (guard >= SETTLE_LIMIT)
            begin
                $display("Timeout: no quiet cycles after the last write or step");
                $display("CHECKS FAILED");
                $fatal(1, "settle wait timed out");
            end
            else
            begin
                tick();
                guard++;
            end
        end
    endtask

    task automatic run_row(input row_t r, input int idx, input int pass);
        logic [31:0] wd;
        logic        use_model;
        use_model = r.by_model || (pass == 1);  // Random pass trusts the model only
        case (r.act)
            ACT_WRITE:
            begin
                wd = r.data;
                if (pass == 1)
                    wd = $random(seed);
                {cfg_wr, cfg_wr_addr, cfg_wr_data} = {1'b1, r.addr, wd};
                tick();
                cfg_wr = 1'b0;
            end
            ACT_STEP:
            begin
                gvp_step = 1'b1;
                for (int i = 0; i < r.cnt; i++)
                    tick();
                gvp_step = 1'b0;
            end
            default:
            begin
                settle();
                rb_addr = r.addr;
                for (int i = 0; i < r.cnt; i++)
                begin
                    tick();
                    if (use_model)
                    begin
                        check_value($sformatf("rb_data.a row %0d", idx), rb_data.a, m_a);
                        check_value($sformatf("rb_data.b row %0d", idx), rb_data.b, m_b);
                    end
                    else if (i == r.cnt - 1)
                    begin
                        check_value($sformatf("rb_data.a row %0d", idx), rb_data.a, r.exp_a);
                        check_value($sformatf("rb_data.b row %0d", idx), rb_data.b, r.exp_b);
                    end
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        seed        = 29;
        rst         = 1'b1;
        cfg_wr      = 1'b0;
        cfg_wr_addr = '0;
        cfg_wr_data = '0;
        gvp_step    = 1'b0;
        rb_addr     = RB_TIMING_RESET;  // Mapped address keeps the arm flag clear
        n_checks    = 0;
        model_reset();
        load_table();

        repeat (2) @(posedge aclk);
        #2;
        rst = 1'b0;
        check_value("rb_data.a after reset", rb_data.a, 32'h0);
        check_value("rb_data.b after reset", rb_data.b, 32'h0);

        // Pass 0 uses the table data, pass 1 random write data
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int idx = 0; idx < rows.size(); idx++)
                run_row(rows[idx], idx, pass);
        end

        $display("%0d values compared", n_checks);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+dv
rtl/spmc_pkg.sv
rtl/config_register_bank.sv
rtl/gvp_ramp.sv
rtl/bias_summer.sv
rtl/readback_configuration.sv
rtl/spmc_readback_top.sv
dv/tb_spmc_readback.sv

/* rtl/bias_summer.sv */
`timescale 1ns/100ps

module bias_summer (
    input  logic                aclk,
    input  logic                rst,
    input  spmc_pkg::cfg_regs_t cfg,
    input  spmc_pkg::gvp_mon_t  gvp,
    output logic [31:0]         bias_sum  // U0 + GVP + modulation, clamped
);
    import spmc_pkg::*;

    // Three 32 bit terms need two guard bits
    localparam int SUM_W = 34;

    // Sign extend one word to the sum width
    function automatic logic signed [SUM_W-1:0] sext(input logic [31:0] w);
        sext = signed'({{(SUM_W-32){w[31]}}, w});
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Wide sum and clamp
    ////////////////////////////////////////////////////////////////////////////

    logic signed [SUM_W-1:0] sum_wide;
    logic signed [SUM_W-1:0] max_wide;
    logic signed [SUM_W-1:0] min_wide;
    logic        [31:0]      sum_sat;

    assign max_wide = sext(BIAS_MAX);
    assign min_wide = sext(BIAS_MIN);
    assign sum_wide = sext(cfg.bias_u0) + sext(gvp.bias_gvp) + sext(cfg.bias_mod);

    always_comb
    begin
        if (sum_wide > max_wide)
            sum_sat = BIAS_MAX;           // Positive overrange
        else if (sum_wide < min_wide)
            sum_sat = BIAS_MIN;           // Negative overrange
        else
            sum_sat = sum_wide[31:0];     // In range, low word is exact
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            bias_sum <= '0;
        end
        else
        begin
            bias_sum <= sum_sat;  // One cycle behind the inputs
        end
    end

endmodule

/* rtl/config_register_bank.sv */
`timescale 1ns/100ps

module config_register_bank (
    input  logic                aclk,
    input  logic                rst,
    input  logic                cfg_wr,       // Write strobe, one cycle
    input  logic [31:0]         cfg_wr_addr,
    input  logic [31:0]         cfg_wr_data,
    output spmc_pkg::cfg_regs_t cfg
);
    import spmc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    logic hit_u0;
    logic hit_mod;
    logic hit_bias_slope;
    logic hit_z_slope;
    logic hit_srcs;
    logic hit_in;
    logic hit_clear;

    // Qualified by the strobe so unknown or idle cycles store nothing
    assign hit_u0         = cfg_wr && (cfg_wr_addr == CFG_BIAS_U0);
    assign hit_mod        = cfg_wr && (cfg_wr_addr == CFG_BIAS_MOD);
    assign hit_bias_slope = cfg_wr && (cfg_wr_addr == CFG_BIAS_SLOPE);
    assign hit_z_slope    = cfg_wr && (cfg_wr_addr == CFG_Z_SLOPE);
    assign hit_srcs       = cfg_wr && (cfg_wr_addr == CFG_SRCS_MUX);
    assign hit_in         = cfg_wr && (cfg_wr_addr == CFG_IN_MUX);
    assign hit_clear      = cfg_wr && (cfg_wr_addr == CFG_GVP_CLEAR);

    ////////////////////////////////////////////////////////////////////////////
    // Stored words
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            cfg <= '0;  // All words and the pulse cleared
        end
        else
        begin
            if (hit_u0)
                cfg.bias_u0 <= cfg_wr_data;
            if (hit_mod)
                cfg.bias_mod <= cfg_wr_data;
            if (hit_bias_slope)
                cfg.bias_slope <= cfg_wr_data;
            if (hit_z_slope)
                cfg.z_slope <= cfg_wr_data;
            if (hit_srcs)
                cfg.srcs_mux_sel <= cfg_wr_data;
            if (hit_in)
                cfg.in_mux_sel <= cfg_wr_data;

            cfg.gvp_clear_pad <= '0;       // Never carries data
            cfg.gvp_clear     <= hit_clear; // High for one cycle after the write
        end
    end

endmodule

/* rtl/gvp_ramp.sv */
`timescale 1ns/100ps

module gvp_ramp (
    input  logic                aclk,
    input  logic                rst,
    input  logic                gvp_step,  // Advance both offsets once
    input  spmc_pkg::cfg_regs_t cfg,
    output spmc_pkg::gvp_mon_t  gvp
);
    import spmc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Next offsets
    ////////////////////////////////////////////////////////////////////////////

    gvp_mon_t           gvp_nxt;
    logic signed [31:0] bias_slope_s;
    logic signed [31:0] z_slope_s;
    logic signed [31:0] bias_acc_s;
    logic signed [31:0] z_acc_s;

    assign bias_slope_s = signed'(cfg.bias_slope);
    assign z_slope_s    = signed'(cfg.z_slope);
    assign bias_acc_s   = signed'(gvp.bias_gvp);
    assign z_acc_s      = signed'(gvp.z_gvp);

    always_comb
    begin
        gvp_nxt = gvp;  // Hold by default

        // Clear wins over a step in the same cycle
        if (cfg.gvp_clear)
        begin
            gvp_nxt = '0;
        end
        else if (gvp_step)
        begin
            // Plain 32 bit add, wraps in two's complement
            gvp_nxt.bias_gvp = 32'(bias_acc_s + bias_slope_s);
            gvp_nxt.z_gvp    = 32'(z_acc_s + z_slope_s);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Offset registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            gvp <= '0;
        end
        else
        begin
            gvp <= gvp_nxt;  // Step on edge k shows after edge k
        end
    end

endmodule

/* rtl/readback_configuration.sv */
`timescale 1ns/100ps

module readback_configuration #(
    parameter logic [31:0] VERSION_ID = 32'h0001_0000,
    parameter logic [31:0] BUILD_DATE = 32'h0000_0001
) (
    input  logic                aclk,
    input  logic                rst,
    input  logic [31:0]         rb_addr,   // Level, sampled every cycle
    input  spmc_pkg::cfg_regs_t cfg,
    input  spmc_pkg::gvp_mon_t  gvp,
    input  logic [31:0]         bias_sum,
    output spmc_pkg::rb_pair_t  rb_data
);
    import spmc_pkg::*;

    // Clock rate the host expects in the timing test
    localparam logic [31:0] TIMING_TEST_WORD = 32'd125000000;

    ////////////////////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////////////////////

    rb_pair_t    pair_nxt;
    logic [31:0] sys_state;      // Counts armed visits to the state address
    logic [31:0] sys_state_nxt;
    logic        startup;        // Cold start flag
    logic        startup_nxt;
    logic        armed;          // Set by any unmapped address
    logic        armed_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Pair select
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        pair_nxt      = '0;
        sys_state_nxt = sys_state;
        startup_nxt   = startup;
        armed_nxt     = armed;

        case (rb_addr)
            RB_Z:
            begin
                pair_nxt.a = gvp.z_gvp;
                pair_nxt.b = cfg.z_slope;
            end
            RB_BIAS:
            begin
                pair_nxt.a = bias_sum;     // Total bias
                pair_nxt.b = cfg.bias_u0;  // Set value
            end
            RB_GVP_BIAS:
            begin
                pair_nxt.a = gvp.bias_gvp;
                pair_nxt.b = cfg.bias_mod;
            end
            RB_SRCS_MUX:
            begin
                pair_nxt.a = cfg.srcs_mux_sel;
                pair_nxt.b = cfg.in_mux_sel;
            end
            RB_IN_MUX:
            begin
                pair_nxt.a = cfg.in_mux_sel;  // B stays zero
            end
            RB_TIMING_TEST:
            begin
                pair_nxt.a = TIMING_TEST_WORD;
                pair_nxt.b = rb_data.a;       // Last A, so B lags by one read
            end
            RB_TIMING_RESET:
            begin
                pair_nxt = '0;                // Restart the counter pattern
            end
            RB_VERSION:
            begin
                pair_nxt.a  = VERSION_ID;
                pair_nxt.b  = BUILD_DATE;
                startup_nxt = 1'b0;           // Cold start seen, never set again
            end
            RB_SYSTEM_STATE:
            begin
                pair_nxt.a = sys_state;
                pair_nxt.b = {31'd0, startup};

                // Only one count per unmapped excursion
                if (armed)
                begin
                    sys_state_nxt = sys_state + 32'd1;
                    armed_nxt     = 1'b0;
                end
            end
            default:
            begin
                // Free running pattern for unknown addresses
                pair_nxt.a = rb_data.a + 32'd1;
                pair_nxt.b = rb_data.a + 32'd13;
                armed_nxt  = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            rb_data   <= '0;
            sys_state <= '0;
            startup   <= 1'b1;  // Reads as cold start until version is read
            armed     <= 1'b0;
        end
        else
        begin
            rb_data   <= pair_nxt;  // One cycle behind rb_addr
            sys_state <= sys_state_nxt;
            startup   <= startup_nxt;
            armed     <= armed_nxt;
        end
    end

endmodule

/* rtl/spmc_pkg.sv */
package spmc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Readback addresses, one word each
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [31:0] RB_Z            = 32'd100001;  // Z offset and slope
    localparam logic [31:0] RB_BIAS         = 32'd100002;  // Bias sum and U0
    localparam logic [31:0] RB_GVP_BIAS     = 32'd100003;  // GVP bias and modulation
    localparam logic [31:0] RB_SRCS_MUX     = 32'd100010;  // Source and input selects
    localparam logic [31:0] RB_IN_MUX       = 32'd100011;  // Input select only
    localparam logic [31:0] RB_TIMING_TEST  = 32'd101999;
    localparam logic [31:0] RB_TIMING_RESET = 32'd102000;
    localparam logic [31:0] RB_VERSION      = 32'd199997;  // Version, build, clears cold start
    localparam logic [31:0] RB_SYSTEM_STATE = 32'd199999;  // State counter, startup flag

    ////////////////////////////////////////////////////////////////////////////
    // Configuration write addresses
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [31:0] CFG_BIAS_U0    = 32'd5001;  // Bias set value
    localparam logic [31:0] CFG_BIAS_MOD   = 32'd5002;  // Modulation bias
    localparam logic [31:0] CFG_BIAS_SLOPE = 32'd5003;  // GVP bias step
    localparam logic [31:0] CFG_Z_SLOPE    = 32'd5004;  // GVP Z step
    localparam logic [31:0] CFG_SRCS_MUX   = 32'd5005;
    localparam logic [31:0] CFG_IN_MUX     = 32'd5006;
    localparam logic [31:0] CFG_GVP_CLEAR  = 32'd5007;  // Data word ignored

    // Symmetric clamp for the bias sum
    localparam logic signed [31:0] BIAS_MAX = 32'sh7FFF_FFFF;
    localparam logic signed [31:0] BIAS_MIN = -32'sh7FFF_FFFF;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] bias_u0;       // Signed bias set value
        logic [31:0] bias_mod;      // Signed modulation term
        logic [31:0] bias_slope;    // Signed, added per step
        logic [31:0] z_slope;       // Signed, added per step
        logic [31:0] srcs_mux_sel;
        logic [31:0] in_mux_sel;
        logic [30:0] gvp_clear_pad; // Keeps the pulse word aligned
        logic        gvp_clear;     // One cycle pulse
    } cfg_regs_t;

    typedef struct packed {
        logic [31:0] bias_gvp;  // Accumulated bias offset
        logic [31:0] z_gvp;     // Accumulated Z offset
    } gvp_mon_t;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
    } rb_pair_t;

endpackage

/* rtl/spmc_readback_top.sv */
`timescale 1ns/100ps

module spmc_readback_top #(
    parameter logic [31:0] VERSION_ID = 32'h0001_0000,  // Release tag
    parameter logic [31:0] BUILD_DATE = 32'h0000_0001   // Build stamp
) (
    input  logic               aclk,
    input  logic               rst,
    input  logic               cfg_wr,       // Host write strobe
    input  logic [31:0]        cfg_wr_addr,
    input  logic [31:0]        cfg_wr_data,
    input  logic               gvp_step,     // Vector generator step
    input  logic [31:0]        rb_addr,
    output spmc_pkg::rb_pair_t rb_data
);
    import spmc_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////////////////////

    cfg_regs_t   cfg;       // Bank to everyone
    gvp_mon_t    gvp;       // Ramp to summer and readback
    logic [31:0] bias_sum;  // Summer to readback

    config_register_bank u_bank (
        .aclk        (aclk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg         (cfg)
    );

    gvp_ramp u_ramp (
        .aclk     (aclk),
        .rst      (rst),
        .gvp_step (gvp_step),
        .cfg      (cfg),
        .gvp      (gvp)
    );

    bias_summer u_summer (
        .aclk     (aclk),
        .rst      (rst),
        .cfg      (cfg),
        .gvp      (gvp),
        .bias_sum (bias_sum)
    );

    readback_configuration #(
        .VERSION_ID (VERSION_ID),
        .BUILD_DATE (BUILD_DATE)
    ) u_readback (
        .aclk     (aclk),
        .rst      (rst),
        .rb_addr  (rb_addr),
        .cfg      (cfg),
        .gvp      (gvp),
        .bias_sum (bias_sum),
        .rb_data  (rb_data)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the readback testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f list.f \
    --top-module tb_spmc_readback \
    -Mdir obj_dir \
    -o tb_spmc_readback

# A $fatal in the testbench gives a nonzero exit status
./obj_dir/tb_spmc_readback
